// File: logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction width
`define DBITS 32
// register number width, 16 registers
`define REGNOBITS 4

// memory sizes as word address widths
`define IMEM_ADDR_BITS 8
`define DMEM_ADDR_BITS 8

// pc step and reset vector
`define INST_SIZE 32'd4
`define START_PC 32'h0000_0100

// memory mapped i/o
`define ADDR_LEDR 32'hFFFF_F020
`define ADDR_SW 32'hFFFF_F090
`define SW_BITS 10

`endif

// File: logic/isa_pkg.sv
package isa_pkg;

  // primary opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    op1_alur = 6'b000000,
    // conditional branches
    op1_beq  = 6'b001000,
    op1_blt  = 6'b001001,
    op1_ble  = 6'b001010,
    op1_bne  = 6'b001011,
    // jump and link through rs
    op1_jal  = 6'b001100,
    // memory access
    op1_lw   = 6'b010010,
    op1_sw   = 6'b011010,
    // immediate alu ops, top bit set
    op1_addi = 6'b100000,
    op1_andi = 6'b100100,
    op1_ori  = 6'b100101,
    op1_xori = 6'b100110
  } op1_e;

  // secondary opcode for alur, instruction bits 25:18
  typedef enum logic [7:0] {
    op2_nop  = 8'b00000000,
    // compares give 0 or 1
    op2_eq   = 8'b00001000,
    op2_lt   = 8'b00001001,
    op2_le   = 8'b00001010,
    op2_ne   = 8'b00001011,
    op2_add  = 8'b00100000,
    op2_and  = 8'b00100100,
    op2_or   = 8'b00100101,
    op2_xor  = 8'b00100110,
    op2_sub  = 8'b00101000,
    op2_nand = 8'b00101100,
    op2_nor  = 8'b00101101,
    op2_nxor = 8'b00101110,
    op2_rshf = 8'b00110000,
    op2_lshf = 8'b00110001
  } op2_e;

endpackage

// File: logic/pipe_pkg.sv
`include "cpu_settings.svh"

package pipe_pkg;

  // fetch latch, 65 bits
  typedef struct packed {
    logic              valid;
    logic [`DBITS-1:0] pc_next;
    logic [`DBITS-1:0] instr;
  } fe_id_t;

  // decode latch
  typedef struct packed {
    logic                  valid;
    logic [`DBITS-1:0]     pc_next;
    isa_pkg::op1_e         op1;
    isa_pkg::op2_e         op2;
    logic [`DBITS-1:0]     val_a;
    logic [`DBITS-1:0]     val_b;
    logic [`DBITS-1:0]     imm;
    logic [`REGNOBITS-1:0] dst;
    logic                  wr_reg;
    logic                  rd_mem;
    logic                  wr_mem;
    logic                  is_br;
    logic                  is_jmp;
  } id_ex_t;

  // execute latch, all flags low means bubble
  typedef struct packed {
    logic [`DBITS-1:0]     result;
    logic [`DBITS-1:0]     st_val;
    logic [`REGNOBITS-1:0] dst;
    logic                  wr_reg;
    logic                  rd_mem;
    logic                  wr_mem;
  } ex_mem_t;

endpackage

// File: logic/reg_dest_if.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

interface reg_dest_if;

  // destination pending in the execute latch
  logic                  ex_busy;
  logic [`REGNOBITS-1:0] ex_regno;

  // write-back port from the memory latch
  logic                  wb_en;
  logic [`REGNOBITS-1:0] wb_regno;
  logic [`DBITS-1:0]     wb_data;

  modport ex_src (output ex_busy, ex_regno);
  modport mem_src (output wb_en, wb_regno, wb_data);
  modport dec_sink (input ex_busy, ex_regno, wb_en, wb_regno, wb_data);

endinterface

// File: logic/fetch_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module fetch_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       prog_we,
  input  logic [`IMEM_ADDR_BITS-1:0] prog_addr,
  input  logic [`DBITS-1:0]          prog_data,
  input  logic                       stall,
  input  logic                       redirect,
  input  logic [`DBITS-1:0]          redirect_pc,
  output pipe_pkg::fe_id_t           fe_out
);

  logic [`DBITS-1:0] imem [0:(1 << `IMEM_ADDR_BITS)-1];
  logic [`DBITS-1:0] pc;
  logic [`DBITS-1:0] pc_next;
  logic [`DBITS-1:0] instr;

  // program load port, word addressed
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // pc is a byte address, drop the low two bits
  assign instr   = imem[pc[`IMEM_ADDR_BITS+1:2]];
  assign pc_next = pc + `INST_SIZE;

  // redirect wins over stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `START_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  // fetch latch, bubble on redirect and hold on stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fe_out <= '0;
    end else if (redirect) begin
      fe_out <= '0;
    end else if (!stall) begin
      fe_out.valid   <= 1'b1;
      fe_out.pc_next <= pc_next;
      fe_out.instr   <= instr;
    end
  end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  pipe_pkg::fe_id_t  fe_in,
  input  logic              redirect,
  reg_dest_if.dec_sink      dest,
  output logic              stall,
  output pipe_pkg::id_ex_t  id_out
);

  logic [`DBITS-1:0]     regs [0:(1 << `REGNOBITS)-1];
  isa_pkg::op1_e         op1;
  isa_pkg::op2_e         op2;
  logic [`REGNOBITS-1:0] rd;
  logic [`REGNOBITS-1:0] rs;
  logic [`REGNOBITS-1:0] rt;
  logic [`DBITS-1:0]     imm_sx;
  logic [`REGNOBITS-1:0] dst;
  logic                  wr_reg;
  logic                  rd_mem;
  logic                  wr_mem;
  logic                  is_br;
  logic                  is_jmp;
  logic                  use_rs;
  logic                  use_rt;
  logic                  haz_rs;
  logic                  haz_rt;

  // instruction fields
  assign op1 = isa_pkg::op1_e'(fe_in.instr[31:26]);
  assign op2 = isa_pkg::op2_e'(fe_in.instr[25:18]);
  assign rd  = fe_in.instr[11:8];
  assign rs  = fe_in.instr[7:4];
  assign rt  = fe_in.instr[3:0];
  // 16 bit immediate overlaps op2 and rd
  assign imm_sx = {{(`DBITS-16){fe_in.instr[23]}}, fe_in.instr[23:8]};

  // control decode and which sources are actually read
  always_comb begin
    dst    = rt;
    wr_reg = 1'b0;
    rd_mem = 1'b0;
    wr_mem = 1'b0;
    is_br  = 1'b0;
    is_jmp = 1'b0;
    use_rs = 1'b0;
    use_rt = 1'b0;
    case (op1)
      isa_pkg::op1_alur: begin
        dst    = rd;
        wr_reg = (op2 != isa_pkg::op2_nop);
        use_rs = 1'b1;
        use_rt = 1'b1;
      end
      isa_pkg::op1_beq, isa_pkg::op1_blt, isa_pkg::op1_ble, isa_pkg::op1_bne: begin
        is_br  = 1'b1;
        use_rs = 1'b1;
        use_rt = 1'b1;
      end
      isa_pkg::op1_jal: begin
        is_jmp = 1'b1;
        wr_reg = 1'b1;
        use_rs = 1'b1;
      end
      isa_pkg::op1_lw: begin
        rd_mem = 1'b1;
        wr_reg = 1'b1;
        use_rs = 1'b1;
      end
      isa_pkg::op1_sw: begin
        // rs is the base, rt the store data
        wr_mem = 1'b1;
        use_rs = 1'b1;
        use_rt = 1'b1;
      end
      isa_pkg::op1_addi, isa_pkg::op1_andi, isa_pkg::op1_ori, isa_pkg::op1_xori: begin
        wr_reg = 1'b1;
        use_rs = 1'b1;
      end
      default: begin
      end
    endcase
    // r0 is hardwired, never a real destination
    if (dst == '0) begin
      wr_reg = 1'b0;
    end
  end

  // interlock against producers in the decode and execute latches
  // the memory latch writes back before the read, so it never blocks
  assign haz_rs = use_rs && (rs != '0) &&
                  ((id_out.wr_reg && id_out.dst == rs) ||
                   (dest.ex_busy && dest.ex_regno == rs));
  assign haz_rt = use_rt && (rt != '0) &&
                  ((id_out.wr_reg && id_out.dst == rt) ||
                   (dest.ex_busy && dest.ex_regno == rt));
  assign stall = fe_in.valid && (haz_rs || haz_rt);

  // register file written on the falling edge
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < (1 << `REGNOBITS); i++) begin
        regs[i] <= '0;
      end
    end else if (dest.wb_en && dest.wb_regno != '0) begin
      regs[dest.wb_regno] <= dest.wb_data;
    end
  end

  // decode latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_out <= '0;
    end else if (stall || redirect || !fe_in.valid) begin
      id_out <= '0;
    end else begin
      id_out.valid   <= 1'b1;
      id_out.pc_next <= fe_in.pc_next;
      id_out.op1     <= op1;
      id_out.op2     <= op2;
      id_out.val_a   <= regs[rs];
      id_out.val_b   <= regs[rt];
      id_out.imm     <= imm_sx;
      id_out.dst     <= dst;
      id_out.wr_reg  <= wr_reg;
      id_out.rd_mem  <= rd_mem;
      id_out.wr_mem  <= wr_mem;
      id_out.is_br   <= is_br;
      id_out.is_jmp  <= is_jmp;
    end
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  pipe_pkg::id_ex_t  id_in,
  reg_dest_if.ex_src        dest,
  output logic              redirect,
  output logic [`DBITS-1:0] redirect_pc,
  output pipe_pkg::ex_mem_t ex_out
);

  logic signed [`DBITS-1:0] a;
  logic signed [`DBITS-1:0] b;
  logic [`DBITS-1:0]        alu_res;
  logic                     br_cond;
  logic                     take;
  logic [`DBITS-1:0]        target;

  // signed view of the operands for compares
  assign a = id_in.val_a;
  assign b = id_in.val_b;

  always_comb begin
    case (id_in.op1)
      isa_pkg::op1_alur: begin
        case (id_in.op2)
          isa_pkg::op2_eq:   alu_res = {{(`DBITS-1){1'b0}}, a == b};
          isa_pkg::op2_lt:   alu_res = {{(`DBITS-1){1'b0}}, a < b};
          isa_pkg::op2_le:   alu_res = {{(`DBITS-1){1'b0}}, a <= b};
          isa_pkg::op2_ne:   alu_res = {{(`DBITS-1){1'b0}}, a != b};
          isa_pkg::op2_add:  alu_res = a + b;
          isa_pkg::op2_and:  alu_res = a & b;
          isa_pkg::op2_or:   alu_res = a | b;
          isa_pkg::op2_xor:  alu_res = a ^ b;
          isa_pkg::op2_sub:  alu_res = a - b;
          isa_pkg::op2_nand: alu_res = ~(a & b);
          isa_pkg::op2_nor:  alu_res = ~(a | b);
          isa_pkg::op2_nxor: alu_res = ~(a ^ b);
          // logical shifts
          isa_pkg::op2_rshf: alu_res = id_in.val_a >> id_in.val_b;
          isa_pkg::op2_lshf: alu_res = id_in.val_a << id_in.val_b;
          default:           alu_res = '0;
        endcase
      end
      // lw and sw compute the byte address
      isa_pkg::op1_addi, isa_pkg::op1_lw, isa_pkg::op1_sw: alu_res = id_in.val_a + id_in.imm;
      isa_pkg::op1_andi: alu_res = id_in.val_a & id_in.imm;
      isa_pkg::op1_ori:  alu_res = id_in.val_a | id_in.imm;
      isa_pkg::op1_xori: alu_res = id_in.val_a ^ id_in.imm;
      // link value
      isa_pkg::op1_jal:  alu_res = id_in.pc_next;
      default:           alu_res = '0;
    endcase
  end

  always_comb begin
    case (id_in.op1)
      isa_pkg::op1_beq: br_cond = (a == b);
      isa_pkg::op1_blt: br_cond = (a < b);
      isa_pkg::op1_ble: br_cond = (a <= b);
      isa_pkg::op1_bne: br_cond = (a != b);
      default:          br_cond = 1'b0;
    endcase
  end

  // branches are pc relative, jal is rs relative, both word offsets
  assign take   = id_in.valid && (id_in.is_jmp || (id_in.is_br && br_cond));
  assign target = id_in.is_br ? id_in.pc_next + (id_in.imm << 2)
                              : id_in.val_a + (id_in.imm << 2);

  // a redirect already in flight squashes the younger one behind it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect <= 1'b0;
    end else begin
      redirect <= take && !redirect;
    end
  end

  always_ff @(posedge clk) begin
    redirect_pc <= target;
  end

  // execute latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_out <= '0;
    end else if (redirect || !id_in.valid) begin
      ex_out <= '0;
    end else begin
      ex_out.result <= alu_res;
      ex_out.st_val <= id_in.val_b;
      ex_out.dst    <= id_in.dst;
      ex_out.wr_reg <= id_in.wr_reg;
      ex_out.rd_mem <= id_in.rd_mem;
      ex_out.wr_mem <= id_in.wr_mem;
    end
  end

  // pending destination for the decode interlock
  assign dest.ex_busy  = ex_out.wr_reg;
  assign dest.ex_regno = ex_out.dst;

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module memory_stage (
  input  logic                clk,
  input  logic                reset,
  input  pipe_pkg::ex_mem_t   ex_in,
  input  logic [`SW_BITS-1:0] sw,
  reg_dest_if.mem_src         dest,
  output logic                io_wr_valid,
  output logic [`DBITS-1:0]   io_wr_data
);

  logic [`DBITS-1:0]           dmem [0:(1 << `DMEM_ADDR_BITS)-1];
  logic [`DMEM_ADDR_BITS-1:0]  dmem_idx;
  logic                        is_led;
  logic                        is_sw;
  logic [`DBITS-1:0]           rd_val;
  logic                        wb_en;
  logic [`REGNOBITS-1:0]       wb_regno;
  logic [`DBITS-1:0]           wb_data;

  // address decode on the alu result
  assign dmem_idx = ex_in.result[`DMEM_ADDR_BITS+1:2];
  assign is_led   = (ex_in.result == `ADDR_LEDR);
  assign is_sw    = (ex_in.result == `ADDR_SW);

  // led port, one cycle strobe per store
  assign io_wr_valid = ex_in.wr_mem && is_led;
  assign io_wr_data  = ex_in.st_val;

  always_ff @(posedge clk) begin
    if (ex_in.wr_mem && !is_led) begin
      dmem[dmem_idx] <= ex_in.st_val;
    end
  end

  // switches read back zero extended
  assign rd_val = is_sw ? {{(`DBITS-`SW_BITS){1'b0}}, sw} : dmem[dmem_idx];

  // memory latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_en <= 1'b0;
    end else begin
      wb_en <= ex_in.wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    wb_regno <= ex_in.dst;
    wb_data  <= ex_in.rd_mem ? rd_val : ex_in.result;
  end

  assign dest.wb_en    = wb_en;
  assign dest.wb_regno = wb_regno;
  assign dest.wb_data  = wb_data;

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       prog_we,
  input  logic [`IMEM_ADDR_BITS-1:0] prog_addr,
  input  logic [`DBITS-1:0]          prog_data,
  input  logic [`SW_BITS-1:0]        sw,
  output logic                       io_wr_valid,
  output logic [`DBITS-1:0]          io_wr_data
);

  pipe_pkg::fe_id_t  fe_id;
  pipe_pkg::id_ex_t  id_ex;
  pipe_pkg::ex_mem_t ex_mem;
  logic              stall;
  logic              redirect;
  logic [`DBITS-1:0] redirect_pc;

  // pending destinations and write-back into decode
  reg_dest_if dest_if ();

  fetch_stage fetch_i (
    .clk         (clk),
    .reset       (reset),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fe_out      (fe_id)
  );

  decode_stage decode_i (
    .clk      (clk),
    .reset    (reset),
    .fe_in    (fe_id),
    .redirect (redirect),
    .dest     (dest_if.dec_sink),
    .stall    (stall),
    .id_out   (id_ex)
  );

  execute_stage execute_i (
    .clk         (clk),
    .reset       (reset),
    .id_in       (id_ex),
    .dest        (dest_if.ex_src),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_out      (ex_mem)
  );

  memory_stage memory_i (
    .clk         (clk),
    .reset       (reset),
    .ex_in       (ex_mem),
    .sw          (sw),
    .dest        (dest_if.mem_src),
    .io_wr_valid (io_wr_valid),
    .io_wr_data  (io_wr_data)
  );

endmodule

// File: verification/cpu_asserts.sv
`timescale 1ns/1ns

module cpu_asserts (
  input logic              clk,
  input logic              reset,
  input logic              io_wr_valid,
  input logic              stall,
  input logic              redirect,
  input pipe_pkg::id_ex_t  id_ex,
  input pipe_pkg::ex_mem_t ex_mem
);

  // led strobe always driven once out of reset
  io_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(io_wr_valid))
    else $error("io_wr_valid is unknown");

  // r0 never heads into write-back with its enable set
  r0_not_written: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.wr_reg && ex_mem.dst == '0))
    else $error("register 0 write reached the execute latch");

  // stalled decode inserts a dead bubble
  stall_bubble: assert property (@(posedge clk) disable iff (reset)
    stall |=> !(id_ex.valid || id_ex.wr_reg || id_ex.wr_mem))
    else $error("decode latch still active after a stall");

  // redirect empties decode and execute latches
  redirect_bubble: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !(id_ex.wr_reg || id_ex.wr_mem || ex_mem.wr_reg || ex_mem.wr_mem))
    else $error("write enable survived a redirect");

endmodule

bind cpu_top cpu_asserts asserts_i (
  .clk         (clk),
  .reset       (reset),
  .io_wr_valid (io_wr_valid),
  .stall       (stall),
  .redirect    (redirect),
  .id_ex       (id_ex),
  .ex_mem      (ex_mem)
);

// File: verification/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_tb;

  localparam int CYCLES_PER_TEST = 2000;
  localparam int IDLE_CYCLES = 50;
  localparam int RESET_CYCLES = 10;

  logic                       clk;
  logic                       reset;
  logic                       prog_we;
  logic [`IMEM_ADDR_BITS-1:0] prog_addr;
  logic [`DBITS-1:0]          prog_data;
  logic [`SW_BITS-1:0]        sw;
  logic                       io_wr_valid;
  logic [`DBITS-1:0]          io_wr_data;

  // records from the data file as kind letter and value pairs
  logic [7:0]        rec_kind [$];
  logic [`DBITS-1:0] rec_val [$];
  int                rec_idx;
  int                num_tests;
  int                watchdog_cycles = 0;

  // expected led words of the running test
  logic [`DBITS-1:0] exp_q [$];
  int                got_count;
  int                cur_test;

  cpu_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .sw          (sw),
    .io_wr_valid (io_wr_valid),
    .io_wr_data  (io_wr_data)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  task automatic check_equal(input logic [`DBITS-1:0] got, input logic [`DBITS-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // whole file into the record queues
  // a lone # starts a comment line
  task automatic read_records();
    int              fd;
    int              code;
    bit              done;
    logic [7:0]      kind;
    logic [`DBITS-1:0] val;
    logic [8*256-1:0]  line;
    fd = $fopen("verification/cpu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verification/cpu_input.txt");
      $display("tests failed");
      $fatal(1, "no stimulus");
    end
    done = 1'b0;
    num_tests = 0;
    while (!done) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        code = $fgets(line, fd);
      end else begin
        code = $fscanf(fd, "%h", val);
        rec_kind.push_back(kind);
        rec_val.push_back(val);
        if (kind == "t") begin
          num_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  // collect one test, load it under reset, then wait for its led words
  task automatic run_test();
    logic [`DBITS-1:0] words [$];
    logic [`DBITS-1:0] word_addr;
    logic [`DBITS-1:0] sw_val;
    int                hold;
    int                i;
    exp_q = {};
    sw_val = '0;
    while (rec_idx < rec_kind.size() && rec_kind[rec_idx] != "t") begin
      case (rec_kind[rec_idx])
        "p": words.push_back(rec_val[rec_idx]);
        "s": sw_val = rec_val[rec_idx];
        "e": exp_q.push_back(rec_val[rec_idx]);
        default: begin
          $display("unknown record kind %c in test %0d", rec_kind[rec_idx], cur_test);
          $display("tests failed");
          $fatal(1, "bad record");
        end
      endcase
      rec_idx++;
    end
    // step over the end-of-test record
    rec_idx++;
    @(negedge clk);
    reset = 1'b1;
    got_count = 0;
    sw = sw_val[`SW_BITS-1:0];
    // reset stays high at least 10 cycles and until the program is in
    hold = (words.size() > RESET_CYCLES) ? words.size() : RESET_CYCLES;
    for (i = 0; i < hold; i++) begin
      if (i < words.size()) begin
        word_addr = (`START_PC / `INST_SIZE) + i;
        prog_we   = 1'b1;
        prog_addr = word_addr[`IMEM_ADDR_BITS-1:0];
        prog_data = words[i];
      end else begin
        prog_we = 1'b0;
      end
      @(negedge clk);
    end
    prog_we = 1'b0;
    reset = 1'b0;
    while (got_count < exp_q.size()) begin
      @(negedge clk);
    end
    // quiet tail where any late word counts as an extra one
    repeat (IDLE_CYCLES) @(negedge clk);
    $display("test %0d done with %0d led words", cur_test, got_count);
  endtask

  // led monitor sampled mid cycle
  always @(negedge clk) begin
    if (!reset && io_wr_valid) begin
      if (got_count < exp_q.size()) begin
        check_equal(io_wr_data, exp_q[got_count],
                    $sformatf("test %0d led word %0d", cur_test, got_count));
      end else begin
        $display("test %0d wrote an unexpected led word %h at %0t ns",
                 cur_test, io_wr_data, $time);
        $display("tests failed");
        $fatal(1, "extra output");
      end
      got_count++;
    end
  end

  // budget follows the number of tests in the file
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("simulation still running after %0d cycles, watchdog stopped it",
             watchdog_cycles);
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    sw = '0;
    got_count = 0;
    rec_idx = 0;
    read_records();
    if (num_tests == 0) begin
      $display("the stimulus file holds no complete test");
      $display("tests failed");
      $fatal(1, "empty stimulus");
    end
    watchdog_cycles = num_tests * CYCLES_PER_TEST;
    for (cur_test = 0; cur_test < num_tests; cur_test++) begin
      run_test();
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: verification/cpu_input.txt
# kind and hex value pairs, several per line, read as a token stream
# p program word from 0x100 up, s switch value, e expected led word, t end of test
# alu ops on r1 = -6 and r2 = 3, each result stored to the led port
p 80fffa01 p 80000302
p 00200312 p 68f02003 e 00000000
p 00240312 p 68f02003 e 00000001
p 00280312 p 68f02003 e 00000001
p 002c0312 p 68f02003 e 00000001
p 00800312 p 68f02003 e fffffffd
p 00900312 p 68f02003 e 00000002
p 00940312 p 68f02003 e fffffffb
p 00980312 p 68f02003 e fffffff9
p 00a00312 p 68f02003 e fffffff7
p 00b00312 p 68f02003 e fffffffd
p 00b40312 p 68f02003 e 00000004
p 00b80312 p 68f02003 e 00000006
p 00c00312 p 68f02003 e 1fffffff
p 00c40312 p 68f02003 e ffffffd0
p 80001014 p 68f02004 e 0000000a
p 9000ff14 p 68f02004 e 000000fa
p 94f00024 p 68f02004 e fffff003
p 98005514 p 68f02004 e ffffffaf
p 20ffff00 t 0
# dependent chain back to back
p 80000501 p 80000712 p 00800321 p 00a00431
p 98000f45 p 68f02003 p 68f02004 p 68f02005
p 20ffff00 e 00000011 e 0000000c e 00000003 t 0
# same chain padded with three nops after each instruction
p 80000501 p 00000000 p 00000000 p 00000000
p 80000712 p 00000000 p 00000000 p 00000000
p 00800321 p 00000000 p 00000000 p 00000000
p 00a00431 p 00000000 p 00000000 p 00000000
p 98000f45 p 00000000 p 00000000 p 00000000
p 68f02003 p 00000000 p 00000000 p 00000000
p 68f02004 p 00000000 p 00000000 p 00000000
p 68f02005 p 20ffff00
e 00000011 e 0000000c e 00000003 t 0
# data memory round trip and switch load
p 80123401 p 68004001 p 48004002 p 68f02002
p 48f09003 p 68f02003 p 20ffff00
s 2a5 e 00001234 e 000002a5 t 0
# branches, jal and a count down loop, r7 stores sit behind taken branches
p 80000201 p 80000502 p 80007707 p 20000112
p 68f02001 p 24000112 p 68f02007 p 28000121
p 68f02002 p 2c000112 p 68f02007 p 20000111
p 68f02007 p 28000111 p 68f02007 p 2c000111
p 68f02001 p 30005408 p 68f02007 p 68f02007
p 68f02008 p 24000121 p 68f02002 p 80000309
p 68f02009 p 80ffff99 p 2cfffd90 p 68f02009
p 20ffff00
e 00000002 e 00000005 e 00000002 e 00000148 e 00000005
e 00000003 e 00000002 e 00000001 e 00000000 t 0

// File: tb.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_dest_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
verification/cpu_asserts.sv
verification/cpu_tb.sv

// File: Makefile
TOP := cpu_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
